// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_versat_lite
FILELIST  ?= versat_lite.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_MSG  ?= All tests passed

SOURCES := $(wildcard design/*.sv) $(wildcard testbench/*.sv) $(wildcard testbench/*.svh)
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR) -o V$(TOP)

# the log decides, the simulator exit code alone does not
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: design/alu_lite.sv
`timescale 1ns/1ps

module alu_lite #(
	parameter int DATA_W = 32,
	parameter int N_BUS = 6,
	parameter int SEL_W = 3
) (
	input  logic                         clk,
	input  logic                         rst,
	input  logic [N_BUS*DATA_W-1:0]      bus,
	input  logic [SEL_W-1:0]             sela,
	input  logic [SEL_W-1:0]             selb,
	input  logic                         loop,
	input  versat_lite_pkg::alu_fns_e    fns,
	output logic [DATA_W-1:0]            result
);

	logic [DATA_W-1:0] op_a;
	logic [DATA_W-1:0] op_b;
	logic [DATA_W-1:0] op_a_q;
	logic [DATA_W-1:0] op_b_q;
	logic [DATA_W-1:0] a_int;
	logic [DATA_W-1:0] res_next;
	logic [DATA_W:0]   a_ext;
	logic [DATA_W:0]   b_ext;
	logic [DATA_W:0]   a_addend;
	logic [DATA_W:0]   sum_ext;
	logic              inv_a;
	logic              b_lt_a;
	logic              a_ctrl;

	// operand muxes from the bus
	assign op_a = bus[sela*DATA_W +: DATA_W];
	assign op_b = bus[selb*DATA_W +: DATA_W];

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			op_a_q <= '0;
			op_b_q <= '0;
		end else begin
			op_a_q <= op_a;
			op_b_q <= op_b;
		end
	end

	// self-loop replaces A with the previous result
	assign a_int = loop ? result : op_a_q;

	// registered A msb acts as control for mux, restart and hold
	assign a_ctrl = op_a_q[DATA_W-1];

	// shared adder, one extra sign bit so B-A never overflows
	assign inv_a    = (fns != versat_lite_pkg::FN_ADD);
	assign a_ext    = {a_int[DATA_W-1], a_int};
	assign b_ext    = {op_b_q[DATA_W-1], op_b_q};
	assign a_addend = inv_a ? ~a_ext : a_ext;
	assign sum_ext  = b_ext + a_addend + {{DATA_W{1'b0}}, inv_a};

	// sign of B-A
	assign b_lt_a = sum_ext[DATA_W];

	always_comb begin
		case (fns)
			versat_lite_pkg::FN_OR: begin
				res_next = a_int | op_b_q;
			end
			versat_lite_pkg::FN_AND: begin
				res_next = a_int & op_b_q;
			end
			versat_lite_pkg::FN_CMP_SIG: begin
				res_next = {b_lt_a, sum_ext[DATA_W-2:0]};
			end
			versat_lite_pkg::FN_MUX: begin
				if (a_ctrl) begin
					res_next = op_b_q;
				end else if (loop) begin
					res_next = result;
				end else begin
					res_next = '0;
				end
			end
			versat_lite_pkg::FN_SUB: begin
				res_next = sum_ext[DATA_W-1:0];
			end
			versat_lite_pkg::FN_ADD: begin
				// accumulator restarts at B
				if (loop && a_ctrl) begin
					res_next = op_b_q;
				end else begin
					res_next = sum_ext[DATA_W-1:0];
				end
			end
			versat_lite_pkg::FN_MAX: begin
				if (loop && a_ctrl) begin
					res_next = result;
				end else if (b_lt_a) begin
					res_next = a_int;
				end else begin
					res_next = op_b_q;
				end
			end
			versat_lite_pkg::FN_MIN: begin
				if (loop && a_ctrl) begin
					res_next = result;
				end else if (b_lt_a) begin
					res_next = op_b_q;
				end else begin
					res_next = a_int;
				end
			end
			default: begin
				res_next = sum_ext[DATA_W-1:0];
			end
		endcase
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			result <= '0;
		end else begin
			result <= res_next;
		end
	end

	// selects come from software through the config slave
	sel_in_range: assert property (@(posedge clk) disable iff (rst)
		(int'(sela) < N_BUS) && (int'(selb) < N_BUS));

endmodule

// File: design/apb_config.sv
`timescale 1ns/1ps

module apb_config #(
	parameter int N_ALU = 4,
	parameter int SEL_W = 3
) (
	input  logic                   clk,
	input  logic                   rst,
	input  logic [11:0]            paddr,
	input  logic                   psel,
	input  logic                   penable,
	input  logic                   pwrite,
	input  logic [31:0]            pwdata,
	output logic [31:0]            prdata,
	output logic                   pready,
	output logic                   pslverr,
	output logic [N_ALU*SEL_W-1:0] sela,
	output logic [N_ALU*SEL_W-1:0] selb,
	output logic [N_ALU-1:0]       loop,
	output logic [N_ALU*3-1:0]     fns,
	output logic [SEL_W-1:0]       out_sel,
	output logic [7:0]             out_lat
);

	localparam int FNS_W = $bits(versat_lite_pkg::alu_fns_e);
	localparam int N_BUS = N_ALU + 2;

	logic [SEL_W-1:0] sela_q [N_ALU];
	logic [SEL_W-1:0] selb_q [N_ALU];
	logic [FNS_W-1:0] fns_q [N_ALU];
	logic [N_ALU-1:0] alu_hit;
	logic             sel_hit;
	logic             lat_hit;
	logic             mapped;
	logic             wr_en;

	assign sel_hit = (paddr == versat_lite_pkg::REG_OUT_SEL);
	assign lat_hit = (paddr == versat_lite_pkg::REG_OUT_LAT);

	for (genvar g = 0; g < N_ALU; g++) begin : g_cfg
		assign alu_hit[g] = (paddr == versat_lite_pkg::REG_ALU_BASE +
			12'(g * versat_lite_pkg::REG_ALU_STRIDE));

		// flatten per-ALU fields
		assign sela[g*SEL_W +: SEL_W] = sela_q[g];
		assign selb[g*SEL_W +: SEL_W] = selb_q[g];
		assign fns[g*FNS_W +: FNS_W]  = fns_q[g];
	end

	assign mapped  = sel_hit | lat_hit | (|alu_hit);
	assign wr_en   = psel & penable & pwrite;

	// zero wait states
	assign pready  = 1'b1;
	assign pslverr = psel & penable & ~mapped;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_sel <= '0;
			out_lat <= '0;
			loop    <= '0;
			for (int i = 0; i < N_ALU; i++) begin
				sela_q[i] <= '0;
				selb_q[i] <= '0;
				fns_q[i]  <= versat_lite_pkg::FN_OR;
			end
		end else if (wr_en) begin
			if (sel_hit) begin
				out_sel <= pwdata[SEL_W-1:0];
			end
			if (lat_hit) begin
				out_lat <= pwdata[7:0];
			end
			for (int i = 0; i < N_ALU; i++) begin
				if (alu_hit[i]) begin
					fns_q[i]  <= pwdata[versat_lite_pkg::CFG_FNS_LSB +: FNS_W];
					loop[i]   <= pwdata[versat_lite_pkg::CFG_LOOP_BIT];
					sela_q[i] <= pwdata[versat_lite_pkg::CFG_SELA_LSB +: SEL_W];
					selb_q[i] <= pwdata[versat_lite_pkg::CFG_SELB_LSB +: SEL_W];
				end
			end
		end
	end

	// readback, fields in place and the rest zero
	always_comb begin
		prdata = '0;
		if (sel_hit) begin
			prdata[SEL_W-1:0] = out_sel;
		end
		if (lat_hit) begin
			prdata[7:0] = out_lat;
		end
		for (int i = 0; i < N_ALU; i++) begin
			if (alu_hit[i]) begin
				prdata[versat_lite_pkg::CFG_FNS_LSB +: FNS_W]  = fns_q[i];
				prdata[versat_lite_pkg::CFG_LOOP_BIT]          = loop[i];
				prdata[versat_lite_pkg::CFG_SELA_LSB +: SEL_W] = sela_q[i];
				prdata[versat_lite_pkg::CFG_SELB_LSB +: SEL_W] = selb_q[i];
			end
		end
	end

	// software must not point an ALU past the end of the bus
	alu_sel_legal: assert property (@(posedge clk) disable iff (rst)
		(wr_en && |alu_hit) |->
		(int'(pwdata[versat_lite_pkg::CFG_SELA_LSB +: versat_lite_pkg::CFG_SEL_W]) < N_BUS) &&
		(int'(pwdata[versat_lite_pkg::CFG_SELB_LSB +: versat_lite_pkg::CFG_SEL_W]) < N_BUS));

	apb_enable_in_select: assert property (@(posedge clk) disable iff (rst)
		penable |-> psel);

endmodule

// File: design/stream_out.sv
`timescale 1ns/1ps

module stream_out #(
	parameter int DATA_W = 32,
	parameter int N_BUS = 6,
	parameter int SEL_W = 3,
	parameter int MAX_LAT = 9
) (
	input  logic                    clk,
	input  logic                    rst,
	input  logic [N_BUS*DATA_W-1:0] bus,
	input  logic [SEL_W-1:0]        out_sel,
	input  logic [7:0]              out_lat,
	input  logic                    in_valid,
	output logic [DATA_W-1:0]       out_data,
	output logic                    out_valid
);

	// vline[k] is in_valid delayed by k+1 cycles
	logic [MAX_LAT-1:0] vline;

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			out_data <= '0;
		end else begin
			out_data <= bus[out_sel*DATA_W +: DATA_W];
		end
	end

	always_ff @(posedge clk or posedge rst) begin
		if (rst) begin
			vline <= '0;
		end else begin
			vline[0] <= in_valid;
			for (int i = 1; i < MAX_LAT; i++) begin
				vline[i] <= vline[i-1];
			end
		end
	end

	// tap select, zero latency passes in_valid through
	always_comb begin
		out_valid = 1'b0;
		if (out_lat == 8'd0) begin
			out_valid = in_valid;
		end
		for (int i = 0; i < MAX_LAT; i++) begin
			if (out_lat == 8'(i + 1)) begin
				out_valid = vline[i];
			end
		end
	end

	lat_in_range: assert property (@(posedge clk) disable iff (rst)
		out_lat <= 8'(MAX_LAT));

endmodule

// File: design/versat_lite.sv
`timescale 1ns/1ps

module versat_lite #(
	parameter int DATA_W = 32,
	parameter int N_ALU = 4
) (
	input  logic              clk,
	input  logic              rst,
	input  logic [11:0]       paddr,
	input  logic              psel,
	input  logic              penable,
	input  logic              pwrite,
	input  logic [31:0]       pwdata,
	output logic [31:0]       prdata,
	output logic              pready,
	output logic              pslverr,
	input  logic [DATA_W-1:0] in_a,
	input  logic [DATA_W-1:0] in_b,
	input  logic              in_valid,
	output logic [DATA_W-1:0] out_data,
	output logic              out_valid
);

	// two inputs then one word per ALU
	localparam int N_BUS   = N_ALU + 2;
	localparam int SEL_W   = $clog2(N_BUS);
	localparam int MAX_LAT = 2 * N_ALU + 1;

	wire [N_BUS*DATA_W-1:0] bus;
	wire [N_ALU*SEL_W-1:0]  sela;
	wire [N_ALU*SEL_W-1:0]  selb;
	wire [N_ALU-1:0]        loop;
	wire [N_ALU*3-1:0]      fns;
	wire [SEL_W-1:0]        out_sel;
	wire [7:0]              out_lat;

	assign bus[0 +: DATA_W]      = in_a;
	assign bus[DATA_W +: DATA_W] = in_b;

	apb_config #(.N_ALU(N_ALU), .SEL_W(SEL_W)) u_cfg (
		.clk(clk), .rst(rst),
		.paddr(paddr), .psel(psel), .penable(penable), .pwrite(pwrite),
		.pwdata(pwdata), .prdata(prdata), .pready(pready), .pslverr(pslverr),
		.sela(sela), .selb(selb), .loop(loop), .fns(fns),
		.out_sel(out_sel), .out_lat(out_lat)
	);

	for (genvar i = 0; i < N_ALU; i++) begin : g_alu
		versat_lite_pkg::alu_fns_e fn;

		assign fn = versat_lite_pkg::alu_fns_e'(fns[i*3 +: 3]);

		alu_lite #(.DATA_W(DATA_W), .N_BUS(N_BUS), .SEL_W(SEL_W)) u_alu (
			.clk(clk), .rst(rst), .bus(bus),
			.sela(sela[i*SEL_W +: SEL_W]), .selb(selb[i*SEL_W +: SEL_W]),
			.loop(loop[i]), .fns(fn),
			.result(bus[(i+2)*DATA_W +: DATA_W])
		);
	end

	stream_out #(
		.DATA_W(DATA_W), .N_BUS(N_BUS), .SEL_W(SEL_W), .MAX_LAT(MAX_LAT)
	) u_out (
		.clk(clk), .rst(rst), .bus(bus),
		.out_sel(out_sel), .out_lat(out_lat), .in_valid(in_valid),
		.out_data(out_data), .out_valid(out_valid)
	);

endmodule

// File: design/versat_lite_pkg.sv
package versat_lite_pkg;

	// ALU function codes, 3 bits in the configuration word
	typedef enum logic [2:0] {
		FN_OR      = 3'd0,
		FN_AND     = 3'd1,
		FN_CMP_SIG = 3'd2,
		FN_MUX     = 3'd3,
		FN_SUB     = 3'd4,
		FN_ADD     = 3'd5,
		FN_MAX     = 3'd6,
		FN_MIN     = 3'd7
	} alu_fns_e;

	// field positions in a per-ALU configuration word
	localparam int CFG_FNS_LSB  = 0;
	localparam int CFG_LOOP_BIT = 3;
	localparam int CFG_SELA_LSB = 8;
	localparam int CFG_SELB_LSB = 16;

	// sela and selb fields are a byte wide each
	localparam int CFG_SEL_W = 8;

	// APB byte offsets
	localparam logic [11:0] REG_OUT_SEL  = 12'h000;
	localparam logic [11:0] REG_OUT_LAT  = 12'h004;
	localparam logic [11:0] REG_ALU_BASE = 12'h010;

	// one word per ALU from REG_ALU_BASE
	localparam int REG_ALU_STRIDE = 4;

endpackage

// File: testbench/alu_lite_model.svh
`ifndef ALU_LITE_MODEL_SVH
`define ALU_LITE_MODEL_SVH

// one ALU step for function fn, self-loop lp, operands a and b, previous result p
function automatic logic [31:0] alu_model(input versat_lite_pkg::alu_fns_e fn,
	input logic lp, input logic [31:0] a, input logic [31:0] b, input logic [31:0] p);
	logic [31:0] opa;
	logic [31:0] diff;
	logic ctrl;
	logic b_less;
	// A is replaced by the previous result in loop mode
	opa = lp ? p : a;
	// the registered A operand top bit always steers mux, restart and hold
	ctrl = a[31];
	diff = b - opa;
	b_less = $signed(b) < $signed(opa);
	case (fn)
		versat_lite_pkg::FN_OR: return opa | b;
		versat_lite_pkg::FN_AND: return opa & b;
		versat_lite_pkg::FN_CMP_SIG: return {b_less, diff[30:0]};
		versat_lite_pkg::FN_MUX: begin
			if (ctrl) begin
				return b;
			end
			return lp ? p : 32'h0;
		end
		versat_lite_pkg::FN_SUB: return diff;
		versat_lite_pkg::FN_ADD: begin
			if (lp && ctrl) begin
				return b;
			end
			return opa + b;
		end
		versat_lite_pkg::FN_MAX: begin
			if (lp && ctrl) begin
				return p;
			end
			return b_less ? opa : b;
		end
		versat_lite_pkg::FN_MIN: begin
			if (lp && ctrl) begin
				return p;
			end
			return b_less ? b : opa;
		end
		default: return 32'h0;
	endcase
endfunction

`endif

// File: testbench/tb_versat_lite.sv
`timescale 1ns/1ps

module tb_versat_lite;

	localparam int DATA_W = 32;
	localparam int N_ALU = 4;
	localparam int CLK_PERIOD = 8;
	localparam int MAX_LAT = 2 * N_ALU + 1;
	// registers, single ALU, chains, loops, latency sweep
	localparam int TEST_CYCLES = 80 + 8 * 25 + 8 * 25 + 5 * 25 + 10 * 15;
	localparam logic [31:0] EDGE_A [5] = '{32'h7fffffff, 32'h80000000, 32'h00000000,
		32'hffffffff, 32'h80000000};
	localparam logic [31:0] EDGE_B [5] = '{32'h80000000, 32'h7fffffff, 32'hffffffff,
		32'h00000000, 32'h80000000};

	`include "alu_lite_model.svh"

	logic clk, rst, psel, penable, pwrite, pready, pslverr, in_valid, out_valid;
	logic [11:0] paddr;
	logic [31:0] pwdata, prdata, in_a, in_b, out_data;
	logic apb_err;
	int seed = 32'h12d37c68;
	int errors = 0;
	int checks = 0;
	logic [31:0] stim_a [$];
	logic [31:0] stim_b [$];
	logic [31:0] exp_q [$];
	logic [31:0] got_q [$];

	versat_lite #(.DATA_W(DATA_W), .N_ALU(N_ALU)) dut (.*);

	initial begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_word(input string name, input logic [31:0] got,
		input logic [31:0] want);
		checks++;
		assert (got === want) else begin
			errors++;
			$display("MISMATCH at %0t: %s got %h expected %h", $time, name, got, want);
		end
	endtask

	// index 0 is out_sel, 1 is out_lat, then one word per ALU
	function automatic logic [11:0] reg_addr(input int idx);
		if (idx == 0) begin
			return versat_lite_pkg::REG_OUT_SEL;
		end else if (idx == 1) begin
			return versat_lite_pkg::REG_OUT_LAT;
		end
		return versat_lite_pkg::REG_ALU_BASE + 12'((idx - 2) * versat_lite_pkg::REG_ALU_STRIDE);
	endfunction

	function automatic logic [31:0] cfg_word(input int sa, input int sb, input logic lp,
		input versat_lite_pkg::alu_fns_e fn);
		logic [31:0] w;
		w = '0;
		w[versat_lite_pkg::CFG_FNS_LSB +: 3] = fn;
		w[versat_lite_pkg::CFG_LOOP_BIT] = lp;
		w[versat_lite_pkg::CFG_SELA_LSB +: 8] = 8'(sa);
		w[versat_lite_pkg::CFG_SELB_LSB +: 8] = 8'(sb);
		return w;
	endfunction

	task automatic apb_write(input logic [11:0] addr, input logic [31:0] data);
		@(posedge clk);
		paddr <= addr;
		pwdata <= data;
		pwrite <= 1'b1;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		apb_err = pslverr;
		check_word("pready", 32'(pready), 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [11:0] addr, output logic [31:0] data);
		@(posedge clk);
		paddr <= addr;
		pwrite <= 1'b0;
		psel <= 1'b1;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);
		data = prdata;
		apb_err = pslverr;
		check_word("pready", 32'(pready), 32'd1);
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic set_output(input int sel, input int lat);
		apb_write(reg_addr(0), 32'(sel));
		apb_write(reg_addr(1), 32'(lat));
	endtask

	task automatic add_sample(input logic [31:0] a, input logic [31:0] b,
		input logic [31:0] want);
		stim_a.push_back(a);
		stim_b.push_back(b);
		exp_q.push_back(want);
	endtask

	// one sample per cycle with the last one held on the inputs
	task automatic stream(input string name);
		int sent;
		int cycles;
		sent = 0;
		cycles = 0;
		got_q.delete();
		while (got_q.size() < stim_a.size() && cycles < stim_a.size() + MAX_LAT + 8) begin
			@(posedge clk);
			if (sent < stim_a.size()) begin
				in_a <= stim_a[sent];
				in_b <= stim_b[sent];
				in_valid <= 1'b1;
				sent++;
			end else begin
				in_valid <= 1'b0;
			end
			@(negedge clk);
			if (out_valid) begin
				got_q.push_back(out_data);
			end
			cycles++;
		end
		@(posedge clk);
		in_valid <= 1'b0;
		checks++;
		assert (got_q.size() == exp_q.size()) else begin
			errors++;
			$display("%s: out_valid timed out after %0d of %0d words", name, got_q.size(),
				exp_q.size());
		end
		for (int k = 0; k < got_q.size() && k < exp_q.size(); k++) begin
			check_word($sformatf("%s [%0d]", name, k), got_q[k], exp_q[k]);
		end
		stim_a.delete();
		stim_b.delete();
		exp_q.delete();
	endtask

	task automatic test_registers();
		logic [31:0] want [N_ALU+2];
		logic [31:0] rd;
		check_word("out_valid after reset", 32'(out_valid), '0);
		want[0] = 32'd5;
		want[1] = 32'd7;
		for (int i = 0; i < N_ALU; i++) begin
			want[i+2] = cfg_word(i + 1, 4 - i, 1'(i % 2), versat_lite_pkg::alu_fns_e'(3'(i + 3)));
		end
		for (int i = 0; i < N_ALU + 2; i++) begin
			apb_read(reg_addr(i), rd);
			check_word($sformatf("prdata reg %0d after reset", i), rd, '0);
			check_word("pslverr", 32'(apb_err), '0);
			apb_write(reg_addr(i), want[i]);
		end
		// unmapped offsets
		apb_write(12'h008, 32'hffffffff);
		check_word("pslverr at 0x008", 32'(apb_err), 32'd1);
		apb_write(12'h020, 32'h00050505);
		check_word("pslverr at 0x020", 32'(apb_err), 32'd1);
		for (int i = 0; i < N_ALU + 2; i++) begin
			apb_read(reg_addr(i), rd);
			check_word($sformatf("prdata reg %0d", i), rd, want[i]);
		end
	endtask

	task automatic test_single_alu();
		logic [31:0] a;
		logic [31:0] b;
		versat_lite_pkg::alu_fns_e fn;
		set_output(2, 3);
		for (int f = 0; f < 8; f++) begin
			fn = versat_lite_pkg::alu_fns_e'(3'(f));
			apb_write(reg_addr(2), cfg_word(0, 1, 1'b0, fn));
			for (int k = 0; k < 12; k++) begin
				a = (k < 5) ? EDGE_A[k] : $random(seed);
				b = (k < 5) ? EDGE_B[k] : $random(seed);
				add_sample(a, b, alu_model(fn, 1'b0, a, b, '0));
			end
			stream($sformatf("out_data %s", fn.name()));
		end
	endtask

	task automatic test_chain();
		logic [31:0] a;
		logic [31:0] b;
		versat_lite_pkg::alu_fns_e fn0;
		versat_lite_pkg::alu_fns_e fn1;
		set_output(3, 5);
		// ALU 1 takes ALU 0 as A and in_b as B
		for (int f = 0; f < 8; f++) begin
			fn0 = versat_lite_pkg::alu_fns_e'(3'(f));
			fn1 = versat_lite_pkg::alu_fns_e'(3'(f + 3));
			apb_write(reg_addr(2), cfg_word(0, 1, 1'b0, fn0));
			apb_write(reg_addr(3), cfg_word(2, 1, 1'b0, fn1));
			for (int k = 0; k < 2; k++) begin
				a = $random(seed);
				b = $random(seed);
				add_sample(a, b, alu_model(fn1, 1'b0, alu_model(fn0, 1'b0, a, b, '0), b, '0));
				stream($sformatf("out_data %s then %s", fn0.name(), fn1.name()));
			end
		end
	endtask

	// mask bit k sets the A top bit of sample k
	task automatic run_loop(input versat_lite_pkg::alu_fns_e fn, input logic [11:0] mask);
		logic [31:0] a;
		logic [31:0] b;
		logic [31:0] prev;
		// zero inputs and a plain OR clear the result register
		@(posedge clk);
		in_a <= '0;
		in_b <= '0;
		apb_write(reg_addr(2), cfg_word(0, 1, 1'b0, versat_lite_pkg::FN_OR));
		apb_write(reg_addr(2), cfg_word(0, 1, 1'b1, fn));
		prev = '0;
		for (int k = 0; k < 12; k++) begin
			a = $random(seed);
			a[31] = mask[k];
			b = $random(seed);
			prev = alu_model(fn, 1'b1, a, b, prev);
			add_sample(a, b, prev);
		end
		stream($sformatf("out_data loop %s", fn.name()));
	endtask

	task automatic test_loop_add();
		set_output(2, 3);
		run_loop(versat_lite_pkg::FN_ADD, 12'h000);
		// one restart in the middle
		run_loop(versat_lite_pkg::FN_ADD, 12'h020);
	endtask

	task automatic test_loop_extremes();
		run_loop(versat_lite_pkg::FN_MAX, 12'h0c4);
		run_loop(versat_lite_pkg::FN_MIN, 12'h30a);
		run_loop(versat_lite_pkg::FN_MUX, 12'h5a3);
	endtask

	task automatic test_latency();
		int d;
		for (int lat = 0; lat <= MAX_LAT; lat++) begin
			apb_write(reg_addr(1), 32'(lat));
			@(negedge clk);
			check_word("out_valid idle", 32'(out_valid), '0);
			@(posedge clk);
			in_valid <= 1'b1;
			@(negedge clk);
			d = 0;
			while (!out_valid && d <= MAX_LAT + 4) begin
				@(posedge clk);
				in_valid <= 1'b0;
				@(negedge clk);
				d++;
			end
			@(posedge clk);
			in_valid <= 1'b0;
			check_word($sformatf("out_valid delay at out_lat %0d", lat), 32'(d), 32'(lat));
			@(negedge clk);
			check_word("out_valid pulse width", 32'(out_valid), '0);
		end
	endtask

	initial begin
		rst <= 1'b1;
		paddr <= '0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		pwdata <= '0;
		in_a <= '0;
		in_b <= '0;
		in_valid <= 1'b0;
		repeat (5) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		test_registers();
		test_single_alu();
		test_chain();
		test_loop_add();
		test_loop_extremes();
		test_latency();
		$display("checks: %0d errors: %0d", checks, errors);
		if (errors == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

	// twice the expected run length
	initial begin
		#(2 * TEST_CYCLES * CLK_PERIOD);
		$display("run did not finish within %0d cycles, %0d errors so far",
			2 * TEST_CYCLES, errors);
		$display("Some tests failed");
		$finish;
	end

endmodule

// File: versat_lite.f
+incdir+testbench
design/versat_lite_pkg.sv
design/alu_lite.sv
design/apb_config.sv
design/stream_out.sv
design/versat_lite.sv
testbench/tb_versat_lite.sv
